// File: include/rd_guard_settings.svh
// ----------------------------------------------------------
// Build settings for the AXI4-Lite read guard
// FIFO depth must be 2 or more
// Counter width limits every budget to 2**CNT_W - 1 ticks
// One tick lasts RD_GUARD_PRESCALE clock cycles
// ----------------------------------------------------------

`ifndef RD_GUARD_SETTINGS_SVH
`define RD_GUARD_SETTINGS_SVH

// Outstanding reads the guard can track
`define RD_GUARD_FIFO_DEPTH 8

// Width of the occupancy count, holds 0 to DEPTH
`define RD_GUARD_FIFO_CNT_W ($clog2(`RD_GUARD_FIFO_DEPTH + 1))

// Budget and elapsed counter width
`define RD_GUARD_CNT_W 8

// Clock cycles per counter tick
`define RD_GUARD_PRESCALE 1

// Observed bus widths
`define RD_GUARD_ADDR_W 32
`define RD_GUARD_DATA_W 32

`endif

// File: hdl/axil_rd_pkg.sv
// ----------------------------------------------------------
// AXI4-Lite read channel types as seen by a passive observer
// Request bundles everything the manager drives
// Response bundles everything the subordinate drives
// ----------------------------------------------------------

`default_nettype none

`include "rd_guard_settings.svh"

package axil_rd_pkg;

  typedef logic [`RD_GUARD_ADDR_W-1:0] axil_addr_t;
  typedef logic [`RD_GUARD_DATA_W-1:0] axil_data_t;
  typedef logic [2:0]                  axil_prot_t;
  typedef logic [1:0]                  axil_resp_t;

  // Manager side: AR channel plus R ready
  typedef struct packed {
    logic       ar_valid;
    axil_addr_t ar_addr;
    axil_prot_t ar_prot;
    logic       r_ready;
  } axil_rd_req_t;

  // Subordinate side: AR ready plus R channel
  typedef struct packed {
    logic       ar_ready;
    logic       r_valid;
    axil_data_t r_data;
    axil_resp_t r_resp;
  } axil_rd_rsp_t;

endpackage

`default_nettype wire

// File: hdl/rd_guard_pkg.sv
// ----------------------------------------------------------
// Types shared by the read guard blocks
// All budgets and ages are in prescaler ticks
// ----------------------------------------------------------

`default_nettype none

`include "rd_guard_settings.svh"

package rd_guard_pkg;

  typedef logic [`RD_GUARD_CNT_W-1:0]  rd_cnt_t;
  typedef logic [`RD_GUARD_ADDR_W-1:0] rd_addr_t;

  // One accepted read still waiting for its R handshake
  typedef struct packed {
    rd_addr_t addr;
    rd_cnt_t  age;
  } rd_txn_t;

  // Budgets, a cause fires once a counter goes above one of these
  typedef struct packed {
    rd_cnt_t budget_ar;
    rd_cnt_t budget_lat;
    rd_cnt_t budget_r;
  } rd_guard_cfg_t;

  typedef struct packed {
    logic ar_stall;
    logic lat;
    logic r_stall;
    logic overflow;
    logic orphan_r;
  } rd_guard_cause_t;

  // Address of the first failure, zero for orphan_r
  typedef struct packed {
    rd_guard_cause_t cause;
    rd_cnt_t         outstanding;
    rd_addr_t        fail_addr;
  } rd_guard_status_t;

endpackage

`default_nettype wire

// File: hdl/rd_ar_tracker.sv
// ----------------------------------------------------------
// AR side of the read guard, observe only
// Counts ticks while AR is stalled by the subordinate
// Pushes one record per AR handshake, never stalls the bus
// A push into a full FIFO is flagged, not held back
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rd_guard_settings.svh"

module rd_ar_tracker (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  axil_rd_pkg::axil_rd_req_t  mst_req_i,
  input  axil_rd_pkg::axil_rd_rsp_t  slv_rsp_i,
  input  logic [`RD_GUARD_CNT_W-1:0] budget_ar_i,
  input  logic                       tick_i,
  input  logic                       fifo_full_i,
  output logic                       push_o,
  output rd_guard_pkg::rd_txn_t      txn_o,
  output logic                       ar_stall_o,
  output logic                       overflow_o
);

  import rd_guard_pkg::*;

  logic    ar_hs;
  logic    ar_wait;
  rd_cnt_t ar_cnt_q;

  assign ar_hs   = mst_req_i.ar_valid & slv_rsp_i.ar_ready;
  assign ar_wait = mst_req_i.ar_valid & ~slv_rsp_i.ar_ready;

  // Stall counter, saturates so a long stall never wraps back under budget
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ar_cnt_q <= '0;
    end else if (!ar_wait) begin
      ar_cnt_q <= '0;
    end else if (tick_i && !(&ar_cnt_q)) begin
      ar_cnt_q <= ar_cnt_q + 1'b1;
    end
  end

  assign ar_stall_o = (ar_cnt_q > budget_ar_i);

  // New record starts aging from zero
  always_comb begin
    txn_o      = '0;
    txn_o.addr = mst_req_i.ar_addr;
    txn_o.age  = '0;
  end

  assign push_o = ar_hs;

  // Record lost, the bus went ahead anyway
  assign overflow_o = ar_hs & fifo_full_i;

endmodule

`default_nettype wire

// File: hdl/rd_txn_fifo.sv
// ----------------------------------------------------------
// In-order FIFO of outstanding read records
// payload_t must carry a counter field named age
// Push while full and pop while empty are ignored
// Count output is registered
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rd_guard_settings.svh"

module rd_txn_fifo #(
  parameter type payload_t = logic
) (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            push_i,
  input  payload_t                        data_i,
  input  logic                            pop_i,
  input  logic                            tick_i,
  output payload_t                        head_o,
  output logic                            empty_o,
  output logic                            full_o,
  output logic [`RD_GUARD_FIFO_CNT_W-1:0] count_o
);

  localparam int unsigned Depth = `RD_GUARD_FIFO_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);

  typedef logic [PtrW-1:0]                 ptr_t;
  typedef logic [`RD_GUARD_FIFO_CNT_W-1:0] cnt_t;

  payload_t mem_q [Depth];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  cnt_t     count_q;
  logic     do_push;
  logic     do_pop;

  // Wraps at Depth, so depth need not be a power of two
  function automatic ptr_t ptr_next(input ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_t'(Depth));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Stale slots age too, harmless since a push overwrites them
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < Depth; i++) begin
      if (do_push && (wr_ptr_q == ptr_t'(i))) begin
        mem_q[i] <= data_i;
      end else if (tick_i && !(&mem_q[i].age)) begin
        mem_q[i].age <= mem_q[i].age + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign head_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;

endmodule

`default_nettype wire

// File: hdl/rd_r_monitor.sv
// ----------------------------------------------------------
// R side of the read guard, owns the tick and the causes
// Causes are sticky until reset_clear_i, clear wins over set
// Failing address is taken from the first failure only
// irq and reset request both mirror the latched cause
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rd_guard_settings.svh"

module rd_r_monitor (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  axil_rd_pkg::axil_rd_req_t       mst_req_i,
  input  axil_rd_pkg::axil_rd_rsp_t       slv_rsp_i,
  input  rd_guard_pkg::rd_guard_cfg_t     cfg_i,
  input  rd_guard_pkg::rd_txn_t           head_i,
  input  logic                            empty_i,
  input  logic [`RD_GUARD_FIFO_CNT_W-1:0] count_i,
  input  logic                            ar_stall_i,
  input  logic                            overflow_i,
  input  logic                            reset_clear_i,
  output logic                            pop_o,
  output logic                            tick_o,
  output logic                            irq_o,
  output logic                            reset_req_o,
  output rd_guard_pkg::rd_guard_status_t  status_o
);

  import rd_guard_pkg::*;

  localparam int unsigned PscW = (`RD_GUARD_PRESCALE > 1) ? $clog2(`RD_GUARD_PRESCALE) : 1;

  logic [PscW-1:0] psc_q;
  logic            r_hs;
  logic            r_wait;
  rd_cnt_t         r_cnt_q;
  rd_guard_cause_t cause_new;
  rd_guard_cause_t cause_q;
  rd_addr_t        fail_addr_d;
  rd_addr_t        fail_addr_q;

  // Prescaler, ticks every cycle when the division is 1
  assign tick_o = (psc_q == PscW'(`RD_GUARD_PRESCALE - 1));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      psc_q <= '0;
    end else if (tick_o) begin
      psc_q <= '0;
    end else begin
      psc_q <= psc_q + 1'b1;
    end
  end

  assign r_hs   = slv_rsp_i.r_valid & mst_req_i.r_ready;
  assign r_wait = slv_rsp_i.r_valid & ~mst_req_i.r_ready;

  // Only a real record leaves the FIFO
  assign pop_o = r_hs & ~empty_i;

  // Ticks spent with R valid but not accepted by the manager
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_cnt_q <= '0;
    end else if (!r_wait) begin
      r_cnt_q <= '0;
    end else if (tick_o && !(&r_cnt_q)) begin
      r_cnt_q <= r_cnt_q + 1'b1;
    end
  end

  always_comb begin
    cause_new          = '0;
    cause_new.ar_stall = ar_stall_i;
    cause_new.lat      = !empty_i && (head_i.age > cfg_i.budget_lat);
    cause_new.r_stall  = (r_cnt_q > cfg_i.budget_r);
    cause_new.overflow = overflow_i;
    cause_new.orphan_r = r_hs & empty_i;
  end

  // Address of the offending read, orphan R has none
  always_comb begin
    fail_addr_d = fail_addr_q;
    if (cause_new.ar_stall || cause_new.overflow) begin
      fail_addr_d = mst_req_i.ar_addr;
    end else if (cause_new.lat || cause_new.r_stall) begin
      fail_addr_d = head_i.addr;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cause_q     <= '0;
      fail_addr_q <= '0;
    end else if (reset_clear_i) begin
      cause_q     <= '0;
      fail_addr_q <= '0;
    end else begin
      cause_q <= cause_q | cause_new;
      if ((cause_q == '0) && (|cause_new)) begin
        fail_addr_q <= fail_addr_d;
      end
    end
  end

  assign irq_o       = |cause_q;
  assign reset_req_o = |cause_q;

  always_comb begin
    status_o             = '0;
    status_o.cause       = cause_q;
    status_o.outstanding = rd_cnt_t'(count_i);
    status_o.fail_addr   = fail_addr_q;
  end

endmodule

`default_nettype wire

// File: hdl/read_guard_top.sv
// ----------------------------------------------------------
// AXI4-Lite read guard for one manager and one subordinate
// Passive: it never drives or stalls the observed link
// Outstanding reads are limited to RD_GUARD_FIFO_DEPTH
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rd_guard_settings.svh"

module read_guard_top (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  axil_rd_pkg::axil_rd_req_t      mst_req_i,
  input  axil_rd_pkg::axil_rd_rsp_t      slv_rsp_i,
  input  rd_guard_pkg::rd_guard_cfg_t    cfg_i,
  input  logic                           reset_clear_i,
  output logic                           irq_o,
  output logic                           reset_req_o,
  output rd_guard_pkg::rd_guard_status_t status_o
);

  import rd_guard_pkg::*;

  logic                            tick;
  logic                            fifo_push;
  logic                            fifo_pop;
  logic                            fifo_empty;
  logic                            fifo_full;
  logic [`RD_GUARD_FIFO_CNT_W-1:0] fifo_count;
  rd_txn_t                         txn_in;
  rd_txn_t                         txn_head;
  logic                            ar_stall;
  logic                            overflow;

  rd_ar_tracker i_ar_tracker (
    .clk_i       ( clk_i           ),
    .arst_n_i    ( arst_n_i        ),
    .mst_req_i   ( mst_req_i       ),
    .slv_rsp_i   ( slv_rsp_i       ),
    .budget_ar_i ( cfg_i.budget_ar ),
    .tick_i      ( tick            ),
    .fifo_full_i ( fifo_full       ),
    .push_o      ( fifo_push       ),
    .txn_o       ( txn_in          ),
    .ar_stall_o  ( ar_stall        ),
    .overflow_o  ( overflow        )
  );

  rd_txn_fifo #(
    .payload_t ( rd_txn_t )
  ) i_txn_fifo (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .push_i   ( fifo_push  ),
    .data_i   ( txn_in     ),
    .pop_i    ( fifo_pop   ),
    .tick_i   ( tick       ),
    .head_o   ( txn_head   ),
    .empty_o  ( fifo_empty ),
    .full_o   ( fifo_full  ),
    .count_o  ( fifo_count )
  );

  rd_r_monitor i_r_monitor (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .mst_req_i     ( mst_req_i     ),
    .slv_rsp_i     ( slv_rsp_i     ),
    .cfg_i         ( cfg_i         ),
    .head_i        ( txn_head      ),
    .empty_i       ( fifo_empty    ),
    .count_i       ( fifo_count    ),
    .ar_stall_i    ( ar_stall      ),
    .overflow_i    ( overflow      ),
    .reset_clear_i ( reset_clear_i ),
    .pop_o         ( fifo_pop      ),
    .tick_o        ( tick          ),
    .irq_o         ( irq_o         ),
    .reset_req_o   ( reset_req_o   ),
    .status_o      ( status_o      )
  );

endmodule

`default_nettype wire

// File: dv/read_guard_chk.sv
// ----------------------------------------------------------
// Concurrent checks on the read guard, attached by bind
// Sampled on the guard clock, the reset check runs in reset
// fail_cnt counts failed assertions for the testbench
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module read_guard_chk (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input axil_rd_pkg::axil_rd_req_t      mst_req_i,
  input axil_rd_pkg::axil_rd_rsp_t      slv_rsp_i,
  input logic                           reset_clear_i,
  input logic                           irq_i,
  input logic                           reset_req_i,
  input rd_guard_pkg::rd_guard_status_t status_i,
  input logic                           pop_i,
  input logic                           empty_i
);

  int unsigned fail_cnt;
  logic        r_hs;

  assign r_hs = slv_rsp_i.r_valid & mst_req_i.r_ready;

  // Causes only accumulate until a clear and irq follows them
  irq_matches_cause: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !reset_clear_i |=> (irq_i == (|status_i.cause)) && (reset_req_i == irq_i) &&
                       ((status_i.cause & $past(status_i.cause)) == $past(status_i.cause))
  ) else begin
    $error("irq_o differs from the latched cause or a cause dropped without a clear");
    fail_cnt++;
  end

  clear_drops_all: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    reset_clear_i |=> !irq_i && !reset_req_i && (status_i.cause == '0)
  ) else begin
    $error("reset_clear_i did not clear irq_o, reset_req_o and the cause");
    fail_cnt++;
  end

  quiet_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> (!irq_i && !reset_req_i)
  ) else begin
    $error("irq_o or reset_req_o high while reset is asserted");
    fail_cnt++;
  end

  // R handshake without a record must not pop and must be flagged
  no_pop_when_empty: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (r_hs && empty_i && !reset_clear_i) |=> !$past(pop_i) && status_i.cause.orphan_r
  ) else begin
    $error("R handshake on an empty FIFO popped or left orphan_r clear");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// File: dv/read_guard_tb.sv
// ----------------------------------------------------------
// Testbench for the AXI4-Lite read guard
// Plays both manager and subordinate, one transfer per channel
// Budgets fixed at AR 12, latency 48, R 12 ticks
// Reference model assumes a prescaler division of 1
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "rd_guard_settings.svh"

module read_guard_tb;

  import axil_rd_pkg::*;
  import rd_guard_pkg::*;

  localparam int unsigned Depth          = `RD_GUARD_FIFO_DEPTH;
  localparam int unsigned BudgetAr       = 12;
  localparam int unsigned BudgetLat      = 48;
  localparam int unsigned BudgetR        = 12;
  localparam int unsigned IrqTimeout     = 200;
  localparam int unsigned WatchdogCycles = 20000;

  localparam rd_guard_cause_t CauseNone     = '0;
  localparam rd_guard_cause_t CauseAr       = '{ar_stall: 1'b1, default: 1'b0};
  localparam rd_guard_cause_t CauseLat      = '{lat: 1'b1, default: 1'b0};
  localparam rd_guard_cause_t CauseR        = '{r_stall: 1'b1, default: 1'b0};
  localparam rd_guard_cause_t CauseOverflow = '{overflow: 1'b1, default: 1'b0};
  localparam rd_guard_cause_t CauseOrphan   = '{orphan_r: 1'b1, default: 1'b0};

  logic             clk;
  logic             arst_n;
  axil_rd_req_t     mst_req;
  axil_rd_rsp_t     slv_rsp;
  rd_guard_cfg_t    cfg;
  logic             reset_clear;
  logic             irq;
  logic             reset_req;
  rd_guard_status_t status;

  integer      seed;
  string       cur_test;
  int unsigned checks;
  int unsigned errors;
  int unsigned err_mark;
  int unsigned tests_run;
  int unsigned tests_failed;
  logic        run_model;

  // Reference model of the outstanding reads
  rd_addr_t        addr_q [$];
  int unsigned     age_q [$];
  int unsigned     ar_waited;
  int unsigned     r_waited;
  rd_guard_cause_t model_cause;

  read_guard_top DUT (
    .clk_i         ( clk         ),
    .arst_n_i      ( arst_n      ),
    .mst_req_i     ( mst_req     ),
    .slv_rsp_i     ( slv_rsp     ),
    .cfg_i         ( cfg         ),
    .reset_clear_i ( reset_clear ),
    .irq_o         ( irq         ),
    .reset_req_o   ( reset_req   ),
    .status_o      ( status      )
  );

  bind read_guard_top read_guard_chk i_chk (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .mst_req_i     ( mst_req_i     ),
    .slv_rsp_i     ( slv_rsp_i     ),
    .reset_clear_i ( reset_clear_i ),
    .irq_i         ( irq_o         ),
    .reset_req_i   ( reset_req_o   ),
    .status_i      ( status_o      ),
    .pop_i         ( fifo_pop      ),
    .empty_i       ( fifo_empty    )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - err_mark);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic rd_addr_t rand_addr();
    return $random(seed) & 32'hffff_fffc;
  endfunction

  // Subordinate holds ar_ready low for delay cycles
  task automatic ar_xfer(input rd_addr_t addr, input int unsigned delay);
    @(posedge clk);
    mst_req.ar_valid <= 1'b1;
    mst_req.ar_addr  <= addr;
    mst_req.ar_prot  <= 3'(rand_below(8));
    repeat (delay) @(posedge clk);
    slv_rsp.ar_ready <= 1'b1;
    @(posedge clk);
    mst_req.ar_valid <= 1'b0;
    slv_rsp.ar_ready <= 1'b0;
  endtask

  // Manager holds r_ready low for ready_delay cycles
  task automatic r_xfer(input int unsigned valid_delay, input int unsigned ready_delay);
    repeat (valid_delay) @(posedge clk);
    @(posedge clk);
    slv_rsp.r_valid <= 1'b1;
    slv_rsp.r_data  <= $random(seed);
    slv_rsp.r_resp  <= 2'b00;
    repeat (ready_delay) @(posedge clk);
    mst_req.r_ready <= 1'b1;
    @(posedge clk);
    slv_rsp.r_valid <= 1'b0;
    mst_req.r_ready <= 1'b0;
  endtask

  task automatic drain(input int unsigned n);
    repeat (n) r_xfer(0, 0);
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    reset_clear <= 1'b1;
    @(posedge clk);
    reset_clear <= 1'b0;
  endtask

  task automatic wait_irq();
    int unsigned n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!irq && n < IrqTimeout);
    if (!irq) begin
      errors++;
      $display("test %s: irq_o did not rise within %0d cycles", cur_test, IrqTimeout);
    end
  endtask

  task automatic check_outputs(input rd_guard_cause_t want);
    repeat (2) @(negedge clk);
    check("cause", want, status.cause);
    check("model cause", model_cause, status.cause);
    check("irq_o", |want, irq);
    check("reset_req_o", |want, reset_req);
  endtask

  // Delays of 0 to 3 cycles keep every wait well under its budget
  task automatic random_traffic(input int unsigned batches);
    int unsigned n;
    for (int b = 0; b < batches; b++) begin
      n = 1 + rand_below(4);
      for (int i = 0; i < n; i++) begin
        ar_xfer(rand_addr(), rand_below(4));
      end
      for (int i = 0; i < n; i++) begin
        r_xfer(rand_below(4), rand_below(4));
      end
    end
  endtask

  // Samples the cycle that ends at this edge like a register would
  always @(posedge clk) begin : ref_model
    int unsigned     old_size;
    logic            ar_hs;
    logic            r_hs;
    rd_guard_cause_t seen;
    if (run_model) begin
      ar_hs    = mst_req.ar_valid && slv_rsp.ar_ready;
      r_hs     = slv_rsp.r_valid && mst_req.r_ready;
      old_size = addr_q.size();
      seen     = '0;
      check("outstanding", old_size, status.outstanding);
      // Wait counters hold the cycles waited before this one
      if (mst_req.ar_valid && !slv_rsp.ar_ready) begin
        seen.ar_stall = (ar_waited > BudgetAr);
        ar_waited++;
      end else begin
        ar_waited = 0;
      end
      if (slv_rsp.r_valid && !mst_req.r_ready) begin
        seen.r_stall = (r_waited > BudgetR);
        r_waited++;
      end else begin
        r_waited = 0;
      end
      seen.lat      = (old_size > 0) && (age_q[0] > BudgetLat);
      seen.orphan_r = r_hs && (old_size == 0);
      seen.overflow = ar_hs && (old_size == Depth);
      if (reset_clear) begin
        model_cause = '0;
      end else begin
        model_cause = model_cause | seen;
      end
      if (r_hs && old_size > 0) begin
        void'(addr_q.pop_front());
        void'(age_q.pop_front());
      end
      foreach (age_q[i]) begin
        age_q[i]++;
      end
      // A read accepted while full is lost
      if (ar_hs && old_size < Depth) begin
        addr_q.push_back(mst_req.ar_addr);
        age_q.push_back(0);
      end
    end
  end

  initial begin : main
    rd_addr_t addr;
    rd_addr_t first_addr;
    seed           = 32'h3dae_6e42;
    cur_test       = "reset";
    arst_n         = 1'b0;
    mst_req        = '0;
    slv_rsp        = '0;
    reset_clear    = 1'b0;
    run_model      = 1'b0;
    model_cause    = '0;
    cfg.budget_ar  = rd_cnt_t'(BudgetAr);
    cfg.budget_lat = rd_cnt_t'(BudgetLat);
    cfg.budget_r   = rd_cnt_t'(BudgetR);
    repeat (3) @(posedge clk);
    arst_n    <= 1'b1;
    run_model <= 1'b1;

    start_test("random_traffic");
    random_traffic(20);
    check_outputs(CauseNone);
    finish_test();

    start_test("ar_stall");
    addr = rand_addr();
    ar_xfer(addr, BudgetAr + 4);
    wait_irq();
    check("fail_addr", addr, status.fail_addr);
    drain(1);
    check_outputs(CauseAr);
    pulse_clear();
    finish_test();

    // Three reads in flight and R held back until the oldest is late
    start_test("latency");
    first_addr = rand_addr();
    ar_xfer(first_addr, 0);
    ar_xfer(rand_addr(), 0);
    ar_xfer(rand_addr(), 0);
    wait_irq();
    check("fail_addr", first_addr, status.fail_addr);
    drain(3);
    check_outputs(CauseLat);
    pulse_clear();
    finish_test();

    start_test("r_stall");
    addr = rand_addr();
    ar_xfer(addr, 0);
    r_xfer(0, BudgetR + 4);
    wait_irq();
    check("fail_addr", addr, status.fail_addr);
    check_outputs(CauseR);
    pulse_clear();
    finish_test();

    start_test("orphan_r");
    r_xfer(0, 0);
    wait_irq();
    check_outputs(CauseOrphan);
    pulse_clear();
    finish_test();

    start_test("overflow");
    for (int i = 0; i <= Depth; i++) begin
      addr = rand_addr();
      ar_xfer(addr, 0);
    end
    wait_irq();
    check("outstanding at full", Depth, status.outstanding);
    check("fail_addr", addr, status.fail_addr);
    drain(Depth);
    check_outputs(CauseOverflow);
    pulse_clear();
    finish_test();

    start_test("clear");
    r_xfer(0, 0);
    wait_irq();
    pulse_clear();
    check_outputs(CauseNone);
    random_traffic(10);
    check_outputs(CauseNone);
    finish_test();

    start_test("assertions");
    check("assertion failures", 0, DUT.i_chk.fail_cnt);
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("simulation stopped, watchdog expired after %0d cycles", WatchdogCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: read_guard_top.f
+incdir+include
hdl/axil_rd_pkg.sv
hdl/rd_guard_pkg.sv
hdl/rd_ar_tracker.sv
hdl/rd_txn_fifo.sv
hdl/rd_r_monitor.sv
hdl/read_guard_top.sv
dv/read_guard_chk.sv
dv/read_guard_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
	  --top-module read_guard_tb -f read_guard_top.f -o read_guard_sim

run: compile
	@out="$$(./obj_dir/read_guard_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
